//--- design/bomb_gate.sv
`timescale 1ns/1ps

module bomb_gate (
    input  logic                            clk,
    input  logic                            rst,
    input  game_pkg::cmd_t                  stage_cmd_i,
    input  logic [game_pkg::BOMB_CNT_W-1:0] bomb_num_i,
    input  logic [game_pkg::BOMB_CNT_W-1:0] bomb_max_i,
    output logic                            set_bomb_o,
    output logic [game_pkg::PLACED_W-1:0]   placed_o
);

    logic [$clog2(game_pkg::BOMB_COOLDOWN + 1)-1:0] cool_q;
    logic                                           set_bomb_q;
    logic [game_pkg::PLACED_W-1:0]                  placed_q;
    logic                                           under_max;
    logic                                           cool_done;
    logic                                           grant;

    assign under_max = (bomb_num_i < bomb_max_i);
    assign cool_done = (cool_q == '0);
    assign grant     = stage_cmd_i.valid && stage_cmd_i.bomb && under_max && cool_done;

    // cooldown counts down every cycle, not only on commands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cool_q <= '0;
        end else if (grant) begin
            cool_q <= ($bits(cool_q))'(game_pkg::BOMB_COOLDOWN);
        end else if (!cool_done) begin
            cool_q <= cool_q - 1'b1;
        end
    end

    // one-cycle pulse per grant
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            set_bomb_q <= 1'b0;
        end else begin
            set_bomb_q <= grant;
        end
    end

    // placed counter sticks at all ones
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            placed_q <= '0;
        end else if (grant && placed_q != '1) begin
            placed_q <= placed_q + 1'b1;
        end
    end

    assign set_bomb_o = set_bomb_q;
    assign placed_o   = placed_q;

    // no grant may follow a cycle where the player was at the limit
    a_limit : assert property (
        @(posedge clk) disable iff (rst)
        !under_max |=> !set_bomb_q
    );

    // pulses are spaced by at least the cooldown
    a_cooldown : assert property (
        @(posedge clk) disable iff (rst)
        set_bomb_q |=> !set_bomb_q [*game_pkg::BOMB_COOLDOWN]
    );

endmodule

//--- design/cmd_capture.sv
`timescale 1ns/1ps

module cmd_capture (
    input  logic              clk,
    input  logic              rst,
    input  game_pkg::cmd_t    cmd_i,
    output game_pkg::cmd_t    stage_cmd_o,
    output game_pkg::facing_t facing_o
);

    logic              stage_valid_q;
    game_pkg::dir_t    stage_dir_q;
    logic              stage_bomb_q;
    game_pkg::facing_t facing_q;

    // valid is a one-cycle flag, cleared when nothing arrives
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_valid_q <= 1'b0;
        end else begin
            stage_valid_q <= cmd_i.valid;
        end
    end

    // command payload, only loaded with a live command
    always_ff @(posedge clk) begin
        if (cmd_i.valid) begin
            stage_dir_q  <= cmd_i.dir;
            stage_bomb_q <= cmd_i.bomb;
        end
    end

    // facing keeps the last real direction, stop leaves it alone
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            facing_q <= game_pkg::DIR_UP[1:0];
        end else if (cmd_i.valid && cmd_i.dir != game_pkg::DIR_STOP) begin
            facing_q <= cmd_i.dir[1:0];
        end
    end

    always_comb begin
        stage_cmd_o.valid = stage_valid_q;
        stage_cmd_o.dir   = stage_dir_q;
        stage_cmd_o.bomb  = stage_bomb_q;
    end

    assign facing_o = facing_q;

endmodule

//--- design/game_controller.sv
`timescale 1ns/1ps

module game_controller (
    input  logic                            clk,
    input  logic                            rst,
    input  game_pkg::cmd_t                  p1_cmd_i,
    input  game_pkg::cmd_t                  p2_cmd_i,
    input  logic [game_pkg::NUM_CELLS-1:0]  wall_map_i,
    input  logic [game_pkg::NUM_CELLS-1:0]  bomb_map_i,
    input  logic [game_pkg::BOMB_CNT_W-1:0] p1_bomb_num_i,
    input  logic [game_pkg::BOMB_CNT_W-1:0] p2_bomb_num_i,
    input  logic [game_pkg::BOMB_CNT_W-1:0] p1_bomb_max_i,
    input  logic [game_pkg::BOMB_CNT_W-1:0] p2_bomb_max_i,
    output game_pkg::status_t               p1_status_o,
    output game_pkg::status_t               p2_status_o
);

    game_pkg::cmd_t                p1_stage_cmd;
    game_pkg::cmd_t                p2_stage_cmd;
    game_pkg::facing_t             p1_facing;
    game_pkg::facing_t             p2_facing;
    game_pkg::cell_u               p1_pos;
    game_pkg::cell_u               p2_pos;
    logic                          p1_set_bomb;
    logic                          p2_set_bomb;
    logic [game_pkg::PLACED_W-1:0] p1_placed;
    logic [game_pkg::PLACED_W-1:0] p2_placed;

    // player 1 lane, starts in the top left corner
    cmd_capture u_p1_capture (
        .clk         (clk),
        .rst         (rst),
        .cmd_i       (p1_cmd_i),
        .stage_cmd_o (p1_stage_cmd),
        .facing_o    (p1_facing)
    );

    move_resolver #(
        .start_cell (game_pkg::cell_u'(0))
    ) u_p1_move (
        .clk         (clk),
        .rst         (rst),
        .stage_cmd_i (p1_stage_cmd),
        .wall_map_i  (wall_map_i),
        .bomb_map_i  (bomb_map_i),
        .pos_o       (p1_pos)
    );

    bomb_gate u_p1_bomb (
        .clk         (clk),
        .rst         (rst),
        .stage_cmd_i (p1_stage_cmd),
        .bomb_num_i  (p1_bomb_num_i),
        .bomb_max_i  (p1_bomb_max_i),
        .set_bomb_o  (p1_set_bomb),
        .placed_o    (p1_placed)
    );

    // player 2 lane, starts in the opposite corner
    cmd_capture u_p2_capture (
        .clk         (clk),
        .rst         (rst),
        .cmd_i       (p2_cmd_i),
        .stage_cmd_o (p2_stage_cmd),
        .facing_o    (p2_facing)
    );

    move_resolver #(
        .start_cell (game_pkg::cell_u'({2{game_pkg::COORD_W'(game_pkg::GRID_DIM - 1)}}))
    ) u_p2_move (
        .clk         (clk),
        .rst         (rst),
        .stage_cmd_i (p2_stage_cmd),
        .wall_map_i  (wall_map_i),
        .bomb_map_i  (bomb_map_i),
        .pos_o       (p2_pos)
    );

    bomb_gate u_p2_bomb (
        .clk         (clk),
        .rst         (rst),
        .stage_cmd_i (p2_stage_cmd),
        .bomb_num_i  (p2_bomb_num_i),
        .bomb_max_i  (p2_bomb_max_i),
        .set_bomb_o  (p2_set_bomb),
        .placed_o    (p2_placed)
    );

    // status words
    assign p1_status_o = '{pos: p1_pos, facing: p1_facing,
                           set_bomb: p1_set_bomb, placed: p1_placed};
    assign p2_status_o = '{pos: p2_pos, facing: p2_facing,
                           set_bomb: p2_set_bomb, placed: p2_placed};

endmodule

//--- design/game_pkg.sv
package game_pkg;

    // board geometry
    localparam int GRID_DIM  = 16;
    localparam int COORD_W   = 4;
    localparam int CELL_W    = 8;
    localparam int NUM_CELLS = 256;

    // bomb bookkeeping
    localparam int BOMB_CNT_W    = 3;
    localparam int PLACED_W      = 4;
    localparam int BOMB_COOLDOWN = 3;

    typedef logic [2:0] dir_t;

    localparam dir_t DIR_UP    = 3'd0;
    localparam dir_t DIR_DOWN  = 3'd1;
    localparam dir_t DIR_LEFT  = 3'd2;
    localparam dir_t DIR_RIGHT = 3'd3;
    localparam dir_t DIR_STOP  = 3'd4;

    // low two bits of a moving direction
    typedef logic [1:0] facing_t;

    typedef struct packed {
        logic valid;
        dir_t dir;
        logic bomb;
    } cmd_t;

    // y sits in the upper half so the flat index is 16*y + x
    typedef struct packed {
        logic [COORD_W-1:0] y;
        logic [COORD_W-1:0] x;
    } coord_t;

    typedef union packed {
        coord_t             xy;
        logic [CELL_W-1:0]  idx;
    } cell_u;

    typedef struct packed {
        cell_u                pos;
        facing_t              facing;
        logic                 set_bomb;
        logic [PLACED_W-1:0]  placed;
    } status_t;

endpackage

//--- design/move_resolver.sv
`timescale 1ns/1ps

module move_resolver #(
    parameter game_pkg::cell_u start_cell = '0
) (
    input  logic                           clk,
    input  logic                           rst,
    input  game_pkg::cmd_t                 stage_cmd_i,
    input  logic [game_pkg::NUM_CELLS-1:0] wall_map_i,
    input  logic [game_pkg::NUM_CELLS-1:0] bomb_map_i,
    output game_pkg::cell_u                pos_o
);

    localparam logic [game_pkg::COORD_W-1:0] last_coord =
        game_pkg::COORD_W'(game_pkg::GRID_DIM - 1);

    game_pkg::cell_u pos_q;
    game_pkg::cell_u nbr;
    logic            has_step;
    logic            edge_hit;
    logic            blocked;
    logic            do_move;

    // neighbor cell in x/y form, plus a flag for leaving the board
    always_comb begin
        nbr      = pos_q;
        has_step = 1'b1;
        edge_hit = 1'b0;
        case (stage_cmd_i.dir)
            game_pkg::DIR_UP: begin
                edge_hit  = (pos_q.xy.y == '0);
                nbr.xy.y  = pos_q.xy.y - 1'b1;
            end
            game_pkg::DIR_DOWN: begin
                edge_hit  = (pos_q.xy.y == last_coord);
                nbr.xy.y  = pos_q.xy.y + 1'b1;
            end
            game_pkg::DIR_LEFT: begin
                edge_hit  = (pos_q.xy.x == '0);
                nbr.xy.x  = pos_q.xy.x - 1'b1;
            end
            game_pkg::DIR_RIGHT: begin
                edge_hit  = (pos_q.xy.x == last_coord);
                nbr.xy.x  = pos_q.xy.x + 1'b1;
            end
            default: begin
                // stop and unused codes
                has_step = 1'b0;
            end
        endcase
    end

    // the flat view of the neighbor is the map bit index
    assign blocked = wall_map_i[nbr.idx] | bomb_map_i[nbr.idx];
    assign do_move = stage_cmd_i.valid && has_step && !edge_hit && !blocked;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos_q <= start_cell;
        end else if (do_move) begin
            pos_q <= nbr;
        end
    end

    assign pos_o = pos_q;

    // true when b is one cell away from a along a single axis
    function automatic logic is_step(game_pkg::cell_u a, game_pkg::cell_u b);
        logic [game_pkg::COORD_W:0] ax;
        logic [game_pkg::COORD_W:0] ay;
        logic [game_pkg::COORD_W:0] bx;
        logic [game_pkg::COORD_W:0] by;
        ax = {1'b0, a.xy.x};
        ay = {1'b0, a.xy.y};
        bx = {1'b0, b.xy.x};
        by = {1'b0, b.xy.y};
        is_step = (ay == by && (ax + 1 == bx || bx + 1 == ax)) ||
                  (ax == bx && (ay + 1 == by || by + 1 == ay));
    endfunction

    // a position change needs a valid stage command and is one step
    a_single_step : assert property (
        @(posedge clk) disable iff (rst)
        (pos_q != $past(pos_q)) |->
            ($past(stage_cmd_i.valid) && is_step($past(pos_q), pos_q))
    );

endmodule

//--- tb.f
design/game_pkg.sv
design/cmd_capture.sv
design/move_resolver.sv
design/bomb_gate.sv
design/game_controller.sv
tests/tb_game_controller.sv

//--- tests/tb_game_controller.sv
`timescale 1ns/1ps

module tb_game_controller;

    // tests take a few hundred cycles, this leaves plenty of margin
    localparam int MAX_CYCLES = 2000;
    localparam game_pkg::cmd_t NO_CMD = '0;

    logic                            clk;
    logic                            rst;
    game_pkg::cmd_t                  cmd_drv [2];
    logic [game_pkg::NUM_CELLS-1:0]  wall_map;
    logic [game_pkg::NUM_CELLS-1:0]  bomb_map;
    logic [game_pkg::BOMB_CNT_W-1:0] num_drv [2];
    logic [game_pkg::BOMB_CNT_W-1:0] max_drv [2];
    game_pkg::status_t               p1_status;
    game_pkg::status_t               p2_status;

    // reference player state
    int                m_x [2];
    int                m_y [2];
    logic [1:0]        m_facing [2];
    logic              m_set [2];
    logic [3:0]        m_placed [2];
    int                m_last_grant [2];
    int                m_cycle;
    game_pkg::cmd_t    m_stage [2];

    logic [15:0] lfsr_q;
    int          cycle_cnt = 0;
    int          checks = 0;
    int          errors = 0;
    int          pulses [2] = '{0, 0};

    game_controller u_game_controller (
        .clk           (clk),
        .rst           (rst),
        .p1_cmd_i      (cmd_drv[0]),
        .p2_cmd_i      (cmd_drv[1]),
        .wall_map_i    (wall_map),
        .bomb_map_i    (bomb_map),
        .p1_bomb_num_i (num_drv[0]),
        .p2_bomb_num_i (num_drv[1]),
        .p1_bomb_max_i (max_drv[0]),
        .p2_bomb_max_i (max_drv[1]),
        .p1_status_o   (p1_status),
        .p2_status_o   (p2_status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // player rules, moves and grants act two edges after the command
    always @(posedge clk or posedge rst) begin : model_update
        int nx;
        int ny;
        if (rst) begin
            m_cycle = 0;
            for (int p = 0; p < 2; p++) begin
                m_stage[p]      = NO_CMD;
                m_facing[p]     = 2'd0;
                m_set[p]        = 1'b0;
                m_placed[p]     = '0;
                m_last_grant[p] = -100;
                m_x[p]          = (p == 0) ? 0 : game_pkg::GRID_DIM - 1;
                m_y[p]          = m_x[p];
            end
        end else begin
            m_cycle = m_cycle + 1;
            for (int p = 0; p < 2; p++) begin
                m_set[p] = 1'b0;
                if (m_stage[p].valid) begin
                    nx = m_x[p];
                    ny = m_y[p];
                    case (m_stage[p].dir)
                        game_pkg::DIR_UP:    ny = ny - 1;
                        game_pkg::DIR_DOWN:  ny = ny + 1;
                        game_pkg::DIR_LEFT:  nx = nx - 1;
                        game_pkg::DIR_RIGHT: nx = nx + 1;
                        default: ;
                    endcase
                    if (nx >= 0 && nx < game_pkg::GRID_DIM && ny >= 0 &&
                        ny < game_pkg::GRID_DIM &&
                        !wall_map[ny * game_pkg::GRID_DIM + nx] &&
                        !bomb_map[ny * game_pkg::GRID_DIM + nx]) begin
                        m_x[p] = nx;
                        m_y[p] = ny;
                    end
                    if (m_stage[p].bomb && num_drv[p] < max_drv[p] &&
                        m_cycle - m_last_grant[p] > game_pkg::BOMB_COOLDOWN) begin
                        m_set[p]        = 1'b1;
                        m_last_grant[p] = m_cycle;
                        if (m_placed[p] != 4'hF)
                            m_placed[p] = m_placed[p] + 1'b1;
                    end
                end
                m_stage[p] = cmd_drv[p];
                if (cmd_drv[p].valid && cmd_drv[p].dir != game_pkg::DIR_STOP)
                    m_facing[p] = cmd_drv[p].dir[1:0];
            end
        end
    end

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic int take_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = (v << 1) | lfsr_q[0];
        end
        return v;
    endfunction

    function automatic game_pkg::cmd_t make_cmd(game_pkg::dir_t d, logic b);
        return '{valid: 1'b1, dir: d, bomb: b};
    endfunction

    function automatic game_pkg::cmd_t rand_cmd();
        game_pkg::cmd_t c;
        c.valid = take_bits(1);
        c.dir   = game_pkg::dir_t'(take_bits(3) % 5);
        c.bomb  = take_bits(1);
        return c;
    endfunction

    task automatic log_error(string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_lanes();
        game_pkg::status_t st;
        for (int p = 0; p < 2; p++) begin
            st = (p == 0) ? p1_status : p2_status;
            checks++;
            if (st.pos.xy.x !== m_x[p] || st.pos.xy.y !== m_y[p])
                log_error($sformatf("player %0d at (%0d,%0d), expected (%0d,%0d)", p + 1,
                          st.pos.xy.x, st.pos.xy.y, m_x[p], m_y[p]));
            if (st.pos.idx !== m_y[p] * game_pkg::GRID_DIM + m_x[p])
                log_error($sformatf("player %0d flat index %0d wrong", p + 1, st.pos.idx));
            if (st.facing !== m_facing[p])
                log_error($sformatf("player %0d facing %0d, expected %0d", p + 1,
                          st.facing, m_facing[p]));
            if (st.set_bomb !== m_set[p])
                log_error($sformatf("player %0d set_bomb %b, expected %b", p + 1,
                          st.set_bomb, m_set[p]));
            if (st.placed !== m_placed[p])
                log_error($sformatf("player %0d placed %0d, expected %0d", p + 1,
                          st.placed, m_placed[p]));
            if (st.set_bomb === 1'b1)
                pulses[p]++;
        end
    endtask

    // outputs settle 1 ns after the edge, then the next inputs go out
    task automatic tick(game_pkg::cmd_t c1, game_pkg::cmd_t c2);
        @(posedge clk);
        #1;
        check_lanes();
        cmd_drv[0] = c1;
        cmd_drv[1] = c2;
    endtask

    task automatic idle(int n);
        repeat (n) tick(NO_CMD, NO_CMD);
    endtask

    task automatic move_pair(game_pkg::dir_t d1, game_pkg::dir_t d2);
        tick(make_cmd(d1, 1'b0), make_cmd(d2, 1'b0));
        idle(2);
    endtask

    task automatic expect_at(int p, int x, int y, game_pkg::dir_t f);
        game_pkg::status_t st;
        st = (p == 0) ? p1_status : p2_status;
        if (st.pos.xy.x !== x || st.pos.xy.y !== y || st.pos.idx !== 16 * y + x ||
            st.facing !== f[1:0])
            log_error($sformatf("player %0d not at (%0d,%0d) facing %0d", p + 1, x, y, f));
    endtask

    task automatic test_reset();
        idle(1);
        expect_at(0, 0, 0, game_pkg::DIR_UP);
        expect_at(1, 15, 15, game_pkg::DIR_UP);
        if (p1_status.set_bomb !== 1'b0 || p1_status.placed !== '0 ||
            p2_status.set_bomb !== 1'b0 || p2_status.placed !== '0)
            log_error("bomb outputs not cleared by reset");
    endtask

    task automatic test_movement();
        move_pair(game_pkg::DIR_RIGHT, game_pkg::DIR_LEFT);
        move_pair(game_pkg::DIR_RIGHT, game_pkg::DIR_UP);
        move_pair(game_pkg::DIR_DOWN, game_pkg::DIR_UP);
        move_pair(game_pkg::DIR_DOWN, game_pkg::DIR_RIGHT);
        move_pair(game_pkg::DIR_LEFT, game_pkg::DIR_DOWN);
        move_pair(game_pkg::DIR_UP, game_pkg::DIR_STOP);
        expect_at(0, 1, 1, game_pkg::DIR_UP);
        expect_at(1, 15, 14, game_pkg::DIR_DOWN);
        // back to back, two commands in flight
        tick(make_cmd(game_pkg::DIR_LEFT, 1'b0), make_cmd(game_pkg::DIR_RIGHT, 1'b0));
        tick(make_cmd(game_pkg::DIR_DOWN, 1'b0), make_cmd(game_pkg::DIR_STOP, 1'b0));
        idle(2);
        expect_at(0, 0, 2, game_pkg::DIR_DOWN);
        expect_at(1, 15, 14, game_pkg::DIR_RIGHT);
    endtask

    task automatic test_blocking();
        move_pair(game_pkg::DIR_LEFT, game_pkg::DIR_RIGHT);
        expect_at(0, 0, 2, game_pkg::DIR_LEFT);
        expect_at(1, 15, 14, game_pkg::DIR_RIGHT);
        move_pair(game_pkg::DIR_UP, game_pkg::DIR_DOWN);
        move_pair(game_pkg::DIR_UP, game_pkg::DIR_DOWN);
        move_pair(game_pkg::DIR_UP, game_pkg::DIR_DOWN);
        expect_at(0, 0, 0, game_pkg::DIR_UP);
        expect_at(1, 15, 15, game_pkg::DIR_DOWN);
        // walls and bombs on the neighbors of both corners
        wall_map[1]   = 1'b1;
        bomb_map[16]  = 1'b1;
        wall_map[254] = 1'b1;
        bomb_map[239] = 1'b1;
        move_pair(game_pkg::DIR_RIGHT, game_pkg::DIR_LEFT);
        expect_at(0, 0, 0, game_pkg::DIR_RIGHT);
        expect_at(1, 15, 15, game_pkg::DIR_LEFT);
        move_pair(game_pkg::DIR_DOWN, game_pkg::DIR_UP);
        expect_at(0, 0, 0, game_pkg::DIR_DOWN);
        expect_at(1, 15, 15, game_pkg::DIR_UP);
        wall_map = '0;
        bomb_map = '0;
    endtask

    task automatic bomb_request(int n_after);
        tick(make_cmd(game_pkg::DIR_STOP, 1'b1), make_cmd(game_pkg::DIR_STOP, 1'b1));
        idle(n_after);
    endtask

    task automatic expect_grants(int p, int pulse_base, int placed_base, int n);
        game_pkg::status_t st;
        st = (p == 0) ? p1_status : p2_status;
        if (pulses[p] != pulse_base + n || st.placed !== placed_base + n)
            log_error($sformatf("player %0d expected %0d new grants, saw %0d pulses",
                      p + 1, n, pulses[p] - pulse_base));
    endtask

    task automatic test_bombs();
        int pb [2];
        int qb [2];
        pb = pulses;
        qb = '{p1_status.placed, p2_status.placed};
        num_drv = '{3'd1, 3'd0};
        max_drv = '{3'd2, 3'd1};
        bomb_request(5);
        expect_grants(0, pb[0], qb[0], 1);
        expect_grants(1, pb[1], qb[1], 1);
        // at the limit
        num_drv = '{3'd2, 3'd1};
        bomb_request(5);
        expect_grants(0, pb[0], qb[0], 1);
        expect_grants(1, pb[1], qb[1], 1);
    endtask

    task automatic test_cooldown();
        int pb [2];
        int qb [2];
        pb = pulses;
        qb = '{p1_status.placed, p2_status.placed};
        num_drv = '{3'd0, 3'd0};
        max_drv = '{3'd7, 3'd7};
        bomb_request(0);
        bomb_request(3);
        expect_grants(0, pb[0], qb[0], 1);
        expect_grants(1, pb[1], qb[1], 1);
        bomb_request(4);
        expect_grants(0, pb[0], qb[0], 2);
        expect_grants(1, pb[1], qb[1], 2);
    endtask

    task automatic test_random_walk();
        game_pkg::cmd_t c1;
        game_pkg::cmd_t c2;
        for (int i = 0; i < game_pkg::NUM_CELLS; i++) begin
            wall_map[i] = (take_bits(2) == 3);
            bomb_map[i] = (take_bits(3) == 7);
        end
        max_drv = '{3'd4, 3'd4};
        repeat (200) begin
            num_drv[0] = take_bits(3);
            num_drv[1] = take_bits(3);
            c1 = rand_cmd();
            c2 = rand_cmd();
            tick(c1, c2);
        end
        idle(3);
        wall_map = '0;
        bomb_map = '0;
    endtask

    initial begin
        lfsr_q   = 16'd69;
        rst      = 1'b1;
        cmd_drv  = '{NO_CMD, NO_CMD};
        wall_map = '0;
        bomb_map = '0;
        num_drv  = '{3'd0, 3'd0};
        max_drv  = '{3'd0, 3'd0};
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_movement();
        test_blocking();
        test_bombs();
        test_cooldown();
        test_random_walk();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
